// File: Makefile
TOP = tb_fc_mem_subsys

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f flist.f --top-module $(TOP)

sim:
	verilator --binary --timing -f flist.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation finished: PASS"

clean:
	rm -rf obj_dir

// File: design/fc_demux.sv
`timescale 1ns/1ps
`default_nettype none

module fc_demux (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          port_sel_i,
    input  logic                          core_req_i,
    input  logic                          core_wen_i,
    input  logic [fc_mem_pkg::ADDR_W-1:0] core_add_i,
    input  logic [fc_mem_pkg::BE_W-1:0]   core_be_i,
    input  logic [fc_mem_pkg::DATA_W-1:0] core_wdata_i,
    output logic                          core_gnt_o,
    output logic                          core_r_valid_o,
    output logic [fc_mem_pkg::DATA_W-1:0] core_r_rdata_o,
    output logic                          tcdm_req_o,
    output logic                          tcdm_wen_o,
    output logic [fc_mem_pkg::ADDR_W-1:0] tcdm_add_o,
    output logic [fc_mem_pkg::BE_W-1:0]   tcdm_be_o,
    output logic [fc_mem_pkg::DATA_W-1:0] tcdm_wdata_o,
    input  logic                          tcdm_gnt_i,
    input  logic                          tcdm_r_valid_i,
    input  logic [fc_mem_pkg::DATA_W-1:0] tcdm_r_rdata_i,
    output logic                          priv_csn_o,
    output logic                          priv_wen_o,
    output logic [fc_mem_pkg::ADDR_W-1:0] priv_add_o,
    output logic [fc_mem_pkg::BE_W-1:0]   priv_be_o,
    output logic [fc_mem_pkg::DATA_W-1:0] priv_wdata_o,
    input  logic [fc_mem_pkg::DATA_W-1:0] priv_rdata_i
);

    import fc_mem_pkg::*;

    demux_state_e state_q;
    demux_state_e state_d;
    dest_e        dest_q;

    logic priv_r_valid_q;
    logic issue_ok;
    logic sel_tcdm;
    logic sel_priv;

    // A new request may only go out when nothing is owed, or the owed response is here now
    assign issue_ok = (state_q == IDLE) | core_r_valid_o;

    assign sel_tcdm = core_req_i & ~port_sel_i & issue_ok;
    assign sel_priv = core_req_i & port_sel_i & issue_ok;

    // TCDM side with fields zeroed when the private path is selected
    assign tcdm_req_o   = sel_tcdm;
    assign tcdm_wen_o   = core_wen_i & ~port_sel_i;
    assign tcdm_add_o   = core_add_i & {ADDR_W{~port_sel_i}};
    assign tcdm_be_o    = core_be_i & {BE_W{~port_sel_i}};
    assign tcdm_wdata_o = core_wdata_i & {DATA_W{~port_sel_i}};

    // Private side gets the same isolation the other way round
    assign priv_csn_o   = ~sel_priv;
    assign priv_wen_o   = core_wen_i & port_sel_i;
    assign priv_add_o   = core_add_i & {ADDR_W{port_sel_i}};
    assign priv_be_o    = core_be_i & {BE_W{port_sel_i}};
    assign priv_wdata_o = core_wdata_i & {DATA_W{port_sel_i}};

    // Grant comes from whichever target port_sel_i points at
    // The SRAM never stalls
    assign core_gnt_o = port_sel_i ? sel_priv : (sel_tcdm & tcdm_gnt_i);

    // Response steering follows the stored destination
    always_comb begin
        core_r_valid_o = 1'b0;
        core_r_rdata_o = tcdm_r_rdata_i;
        if (state_q == VALID) begin
            if (dest_q == DEST_PRIV) begin
                core_r_valid_o = priv_r_valid_q;
                core_r_rdata_o = priv_rdata_i;
            end else begin
                core_r_valid_o = tcdm_r_valid_i;
            end
        end
    end

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            IDLE: begin
                if (core_gnt_o) begin
                    state_d = VALID;
                end
            end
            VALID: begin
                // Stay busy when a back-to-back request is granted on the response cycle
                if (core_r_valid_o && !core_gnt_o) begin
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q        <= IDLE;
            dest_q         <= DEST_TCDM;
            priv_r_valid_q <= 1'b0;
        end else begin
            state_q        <= state_d;
            priv_r_valid_q <= core_gnt_o & port_sel_i;
            if (core_gnt_o) begin
                dest_q <= port_sel_i ? DEST_PRIV : DEST_TCDM;
            end
        end
    end

endmodule

`default_nettype wire

// File: design/fc_mem_pkg.sv
`default_nettype none

package fc_mem_pkg;

    // Core port widths
    localparam int unsigned ADDR_W = 32;
    localparam int unsigned DATA_W = 32;
    localparam int unsigned BE_W   = DATA_W / 8;

    // Demux tracks at most one outstanding transaction
    typedef enum logic {
        IDLE,
        VALID
    } demux_state_e;

    // Source of the pending response
    typedef enum logic {
        DEST_TCDM,
        DEST_PRIV
    } dest_e;

endpackage

`default_nettype wire

// File: design/fc_mem_subsys.sv
`timescale 1ns/1ps
`default_nettype none

module fc_mem_subsys #(
    parameter int unsigned TCDM_WORDS = 256,
    parameter int unsigned PRIV_WORDS = 128,
    parameter int unsigned TCDM_STALL = 2
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          port_sel_i,
    input  logic                          req_i,
    input  logic                          wen_i,
    input  logic [fc_mem_pkg::ADDR_W-1:0] add_i,
    input  logic [fc_mem_pkg::BE_W-1:0]   be_i,
    input  logic [fc_mem_pkg::DATA_W-1:0] wdata_i,
    output logic                          gnt_o,
    output logic                          r_valid_o,
    output logic [fc_mem_pkg::DATA_W-1:0] r_rdata_o
);

    import fc_mem_pkg::*;

    // TCDM link
    logic              tcdm_req;
    logic              tcdm_wen;
    logic [ADDR_W-1:0] tcdm_add;
    logic [BE_W-1:0]   tcdm_be;
    logic [DATA_W-1:0] tcdm_wdata;
    logic              tcdm_gnt;
    logic              tcdm_r_valid;
    logic [DATA_W-1:0] tcdm_r_rdata;

    // Private SRAM link
    logic              priv_csn;
    logic              priv_wen;
    logic [ADDR_W-1:0] priv_add;
    logic [BE_W-1:0]   priv_be;
    logic [DATA_W-1:0] priv_wdata;
    logic [DATA_W-1:0] priv_rdata;

    fc_demux u_demux (
        .clk            (clk),
        .rst_n          (rst_n),
        .port_sel_i     (port_sel_i),
        .core_req_i     (req_i),
        .core_wen_i     (wen_i),
        .core_add_i     (add_i),
        .core_be_i      (be_i),
        .core_wdata_i   (wdata_i),
        .core_gnt_o     (gnt_o),
        .core_r_valid_o (r_valid_o),
        .core_r_rdata_o (r_rdata_o),
        .tcdm_req_o     (tcdm_req),
        .tcdm_wen_o     (tcdm_wen),
        .tcdm_add_o     (tcdm_add),
        .tcdm_be_o      (tcdm_be),
        .tcdm_wdata_o   (tcdm_wdata),
        .tcdm_gnt_i     (tcdm_gnt),
        .tcdm_r_valid_i (tcdm_r_valid),
        .tcdm_r_rdata_i (tcdm_r_rdata),
        .priv_csn_o     (priv_csn),
        .priv_wen_o     (priv_wen),
        .priv_add_o     (priv_add),
        .priv_be_o      (priv_be),
        .priv_wdata_o   (priv_wdata),
        .priv_rdata_i   (priv_rdata)
    );

    tcdm_bank #(
        .TCDM_WORDS (TCDM_WORDS),
        .TCDM_STALL (TCDM_STALL)
    ) u_tcdm_bank (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_i     (tcdm_req),
        .wen_i     (tcdm_wen),
        .add_i     (tcdm_add),
        .be_i      (tcdm_be),
        .wdata_i   (tcdm_wdata),
        .gnt_o     (tcdm_gnt),
        .r_valid_o (tcdm_r_valid),
        .r_rdata_o (tcdm_r_rdata)
    );

    fc_private_sram #(
        .PRIV_WORDS (PRIV_WORDS)
    ) u_priv_sram (
        .clk     (clk),
        .csn_i   (priv_csn),
        .wen_i   (priv_wen),
        .add_i   (priv_add),
        .be_i    (priv_be),
        .wdata_i (priv_wdata),
        .rdata_o (priv_rdata)
    );

endmodule

`default_nettype wire

// File: design/fc_private_sram.sv
`timescale 1ns/1ps
`default_nettype none

module fc_private_sram #(
    parameter int unsigned PRIV_WORDS = 128
) (
    input  logic                          clk,
    input  logic                          csn_i,
    input  logic                          wen_i,
    input  logic [fc_mem_pkg::ADDR_W-1:0] add_i,
    input  logic [fc_mem_pkg::BE_W-1:0]   be_i,
    input  logic [fc_mem_pkg::DATA_W-1:0] wdata_i,
    output logic [fc_mem_pkg::DATA_W-1:0] rdata_o
);

    import fc_mem_pkg::*;

    localparam int unsigned IDX_W = $clog2(PRIV_WORDS);

    logic [DATA_W-1:0] mem_q [PRIV_WORDS];
    logic [IDX_W-1:0]  idx;
    logic [DATA_W-1:0] rdata_q;

    assign idx = add_i[2 +: IDX_W];

    // Access only while chip select is low and read data holds otherwise
    always_ff @(posedge clk) begin
        if (!csn_i) begin
            if (wen_i) begin
                rdata_q <= mem_q[idx];
            end else begin
                for (int b = 0; b < BE_W; b++) begin
                    if (be_i[b]) begin
                        mem_q[idx][b*8 +: 8] <= wdata_i[b*8 +: 8];
                    end
                end
            end
        end
    end

    assign rdata_o = rdata_q;

endmodule

`default_nettype wire

// File: design/tcdm_bank.sv
`timescale 1ns/1ps
`default_nettype none

module tcdm_bank #(
    parameter int unsigned TCDM_WORDS = 256,
    parameter int unsigned TCDM_STALL = 2
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          req_i,
    input  logic                          wen_i,
    input  logic [fc_mem_pkg::ADDR_W-1:0] add_i,
    input  logic [fc_mem_pkg::BE_W-1:0]   be_i,
    input  logic [fc_mem_pkg::DATA_W-1:0] wdata_i,
    output logic                          gnt_o,
    output logic                          r_valid_o,
    output logic [fc_mem_pkg::DATA_W-1:0] r_rdata_o
);

    import fc_mem_pkg::*;

    localparam int unsigned IDX_W = $clog2(TCDM_WORDS);
    localparam int unsigned CNT_W = (TCDM_STALL > 0) ? $clog2(TCDM_STALL + 1) : 1;
    localparam logic [CNT_W-1:0] STALL_CNT = CNT_W'(TCDM_STALL);

    logic [DATA_W-1:0] mem_q [TCDM_WORDS];
    logic [IDX_W-1:0]  idx;
    logic [CNT_W-1:0]  stall_cnt_q;
    logic              r_valid_q;
    logic [DATA_W-1:0] r_rdata_q;

    // Word address wraps on the bank depth
    assign idx = add_i[2 +: IDX_W];

    // Grant only once the request has waited out the contention window
    assign gnt_o = req_i & (stall_cnt_q == STALL_CNT);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stall_cnt_q <= '0;
            r_valid_q   <= 1'b0;
        end else begin
            r_valid_q <= gnt_o;
            if (req_i && !gnt_o) begin
                stall_cnt_q <= stall_cnt_q + 1'b1;
            end else begin
                stall_cnt_q <= '0;
            end
        end
    end

    // Array and read data
    always_ff @(posedge clk) begin
        if (gnt_o) begin
            if (wen_i) begin
                r_rdata_q <= mem_q[idx];
            end else begin
                for (int b = 0; b < BE_W; b++) begin
                    if (be_i[b]) begin
                        mem_q[idx][b*8 +: 8] <= wdata_i[b*8 +: 8];
                    end
                end
            end
        end
    end

    assign r_valid_o = r_valid_q;
    assign r_rdata_o = r_rdata_q;

endmodule

`default_nettype wire

// File: flist.f
design/fc_mem_pkg.sv
design/fc_private_sram.sv
design/tcdm_bank.sv
design/fc_demux.sv
design/fc_mem_subsys.sv
testbench/tb_fc_mem_subsys.sv

// File: testbench/fc_mem_stimulus.txt
# sel (1 private, 0 tcdm)  wen (1 read, 0 write)  chain (1 no idle gap)  addr  be  wdata  exp_rdata
# All values hex, exp_rdata is ignored for writes
1 0 0 00000010 f 11223344 00000000
1 1 0 00000010 f 00000000 11223344
0 0 0 00000020 f a5a55a5a 00000000
0 1 0 00000020 f 00000000 a5a55a5a
# Partial writes keep the old bytes where be is clear
1 0 0 00000014 f deadbeef 00000000
1 0 0 00000014 5 00112233 00000000
1 1 0 00000014 f 00000000 de11be33
1 0 0 00000018 f 01020304 00000000
1 0 0 00000018 c aabbccdd 00000000
1 1 0 00000018 f 00000000 aabb0304
0 0 0 00000024 f cafef00d 00000000
0 0 0 00000024 a 12345678 00000000
0 1 0 00000024 f 00000000 12fe560d
0 0 0 00000028 f 00000000 00000000
0 0 0 00000028 1 ffffff7e 00000000
0 1 0 00000028 f 00000000 0000007e
# Same address in both memories
1 0 0 00000040 f 0badcafe 00000000
0 0 0 00000040 f 5eedf00d 00000000
1 1 0 00000040 f 00000000 0badcafe
0 1 0 00000040 f 00000000 5eedf00d
# Word address wraps on the memory depth
0 0 0 00000404 f 77665544 00000000
0 1 0 00000004 f 00000000 77665544
1 0 0 00000208 f 99aabbcc 00000000
1 1 0 00000008 f 00000000 99aabbcc
# Alternating targets, each request issued in the response cycle of the previous one
0 1 0 00000020 f 00000000 a5a55a5a
1 1 1 00000010 f 00000000 11223344
0 1 1 00000024 f 00000000 12fe560d
1 1 1 00000014 f 00000000 de11be33
1 0 1 00000044 f 13572468 00000000
0 0 1 00000044 f 24681357 00000000
1 1 1 00000044 f 00000000 13572468
0 1 1 00000044 f 00000000 24681357
1 1 1 00000040 f 00000000 0badcafe
0 1 1 00000040 f 00000000 5eedf00d

// File: testbench/tb_fc_mem_subsys.sv
`timescale 1ns/1ps
`default_nettype none

module tb_fc_mem_subsys;

    import fc_mem_pkg::*;

    localparam int CLK_PERIOD = 20;
    localparam int SAMPLE_DLY = 5;
    localparam int TCDM_STALL = 2;
    localparam int MAX_WAIT   = 50;

    logic              clk;
    logic              rst_n;
    logic              port_sel_i;
    logic              req_i;
    logic              wen_i;
    logic [ADDR_W-1:0] add_i;
    logic [BE_W-1:0]   be_i;
    logic [DATA_W-1:0] wdata_i;
    logic              gnt_o;
    logic              r_valid_o;
    logic [DATA_W-1:0] r_rdata_o;

    logic [31:0]      lfsr_q;
    logic [8*256-1:0] line;
    logic [31:0]      f_sel;
    logic [31:0]      f_wen;
    logic [31:0]      f_chain;
    logic [31:0]      f_addr;
    logic [31:0]      f_be;
    logic [31:0]      f_wdata;
    logic [31:0]      f_exp;
    int               fd;
    int               rc;
    int               n_fields;
    int               n_txn;
    int               n_gnt;
    int               n_rvalid;
    int               err_data;
    int               err_timing;
    int               err_proto;
    bit               aborted;

    fc_mem_subsys #(
        .TCDM_WORDS (256),
        .PRIV_WORDS (128),
        .TCDM_STALL (TCDM_STALL)
    ) dut_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .port_sel_i (port_sel_i),
        .req_i      (req_i),
        .wen_i      (wen_i),
        .add_i      (add_i),
        .be_i       (be_i),
        .wdata_i    (wdata_i),
        .gnt_o      (gnt_o),
        .r_valid_o  (r_valid_o),
        .r_rdata_o  (r_rdata_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Galois LFSR with taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic take_rand_bit(output logic b);
        lfsr_q = lfsr_next(lfsr_q);
        b      = lfsr_q[0];
    endtask

    task automatic idle_gap();
        logic       hi;
        logic       lo;
        logic [1:0] gap;
        take_rand_bit(hi);
        take_rand_bit(lo);
        gap = {hi, lo};
        repeat (gap) @(negedge clk);
    endtask

    // Grants and responses counted once per cycle after inputs have settled
    initial begin
        n_gnt    = 0;
        n_rvalid = 0;
        forever begin
            @(negedge clk);
            #SAMPLE_DLY;
            if (gnt_o === 1'b1) begin
                n_gnt++;
            end
            if (r_valid_o === 1'b1) begin
                n_rvalid++;
            end
        end
    end

    // Entered on a falling edge and returns on the falling edge of the response cycle
    task automatic run_txn(input logic sel, input logic wen, input logic [ADDR_W-1:0] addr,
                           input logic [BE_W-1:0] be, input logic [DATA_W-1:0] wdata,
                           input logic [DATA_W-1:0] exp_data);
        int stall;
        int lat;
        int exp_stall;
        exp_stall  = sel ? 0 : TCDM_STALL;
        port_sel_i = sel;
        req_i      = 1'b1;
        wen_i      = wen;
        add_i      = addr;
        be_i       = be;
        wdata_i    = wdata;
        stall      = 0;
        // gnt is combinational, so look at it once the new inputs have settled
        #SAMPLE_DLY;
        while (gnt_o !== 1'b1 && stall < MAX_WAIT) begin
            @(negedge clk);
            #SAMPLE_DLY;
            stall++;
        end
        if (gnt_o !== 1'b1) begin
            $display("Timeout: no grant for address 0x%08h within %0d cycles", addr, MAX_WAIT);
            err_proto++;
            aborted = 1'b1;
            return;
        end
        if (stall != exp_stall) begin
            $display("[FAIL] %0t: grant for 0x%08h after %0d cycles, expected %0d",
                     $time, addr, stall, exp_stall);
            err_timing++;
        end
        @(negedge clk);
        req_i   = 1'b0;
        wen_i   = 1'b0;
        add_i   = '0;
        be_i    = '0;
        wdata_i = '0;
        lat     = 1;
        while (r_valid_o !== 1'b1 && lat < MAX_WAIT) begin
            @(negedge clk);
            lat++;
        end
        if (r_valid_o !== 1'b1) begin
            $display("Timeout: no response for address 0x%08h within %0d cycles", addr, MAX_WAIT);
            err_proto++;
            aborted = 1'b1;
            return;
        end
        if (lat != 1) begin
            $display("[FAIL] %0t: response for 0x%08h %0d cycles after grant, expected 1",
                     $time, addr, lat);
            err_timing++;
        end
        if (wen && r_rdata_o !== exp_data) begin
            $display("[FAIL] %0t: read at 0x%08h expected 0x%08h got 0x%08h",
                     $time, addr, exp_data, r_rdata_o);
            err_data++;
        end
    endtask

    initial begin
        rst_n      = 1'b0;
        port_sel_i = 1'b0;
        req_i      = 1'b0;
        wen_i      = 1'b0;
        add_i      = '0;
        be_i       = '0;
        wdata_i    = '0;
        lfsr_q     = 32'h15a2;
        n_txn      = 0;
        err_data   = 0;
        err_timing = 0;
        err_proto  = 0;
        aborted    = 1'b0;

        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        if (gnt_o !== 1'b0 || r_valid_o !== 1'b0) begin
            $display("[FAIL] %0t: outputs not idle after reset, gnt=%b r_valid=%b",
                     $time, gnt_o, r_valid_o);
            err_proto++;
        end

        fd = $fopen("testbench/fc_mem_stimulus.txt", "r");
        if (fd == 0) begin
            $display("Could not open testbench/fc_mem_stimulus.txt");
            err_proto++;
            aborted = 1'b1;
        end
        while (!aborted && !$feof(fd)) begin
            rc       = $fgets(line, fd);
            n_fields = $sscanf(line, "%h %h %h %h %h %h %h",
                               f_sel, f_wen, f_chain, f_addr, f_be, f_wdata, f_exp);
            // Comment and blank lines do not parse into seven fields
            if (rc > 0 && n_fields == 7) begin
                if (n_txn > 0 && f_chain[0] == 1'b0) begin
                    idle_gap();
                end
                run_txn(f_sel[0], f_wen[0], f_addr, f_be[BE_W-1:0], f_wdata, f_exp);
                n_txn++;
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end

        // Let any stray response show up in the counts
        repeat (3) @(negedge clk);
        if (!aborted && (n_gnt != n_txn || n_rvalid != n_txn)) begin
            $display("[FAIL] %0t: %0d transactions but %0d grants and %0d responses",
                     $time, n_txn, n_gnt, n_rvalid);
            err_proto++;
        end

        $display("Errors: %0d data, %0d timing, %0d protocol over %0d transactions",
                 err_data, err_timing, err_proto, n_txn);
        if (!aborted && err_data + err_timing + err_proto == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
